// File: hw/obj_pkg.sv
// sprite engine widths
`default_nettype none

package obj_pkg;

    // object table entry, four 16-bit words
    localparam int obj_entry_w = 64;            // {attr, code, y, x}, x lowest
    localparam int field_w     = 16;            // one word of an entry

    // tiles
    localparam int tile_px = 16;                // pixels per tile side
    localparam int sub_w   = $clog2(tile_px);   // row / column inside a tile
    localparam int pix_w   = 4;                 // pixel index
    localparam logic [pix_w-1:0] pix_clear = '1; // index 15 is see-through

    // line buffer
    localparam int pal_w   = 5;                 // attr[4:0]
    localparam int lbuf_aw = 9;                 // 512 positions
    localparam int lbuf_dw = 1 + pal_w + pix_w; // {valid, pal, pix}
    localparam int hpos_w  = lbuf_aw + 1;       // top bit set means off the line

    // graphics rom
    localparam int gfx_w  = tile_px * pix_w;    // one tile row, pixel 0 lowest
    localparam int gfx_aw = field_w + sub_w;    // {code, vsub}

endpackage

`default_nettype wire

// File: hw/obj_table_ram.sv
// object table memory
`default_nettype none
`timescale 1ns/10ps

module obj_table_ram import obj_pkg::*; #(
    parameter int table_aw = 8
) (
    input  logic                   clk,
    input  logic                   we,
    input  logic [table_aw-1:0]    addr,
    input  logic [obj_entry_w-1:0] wdata,
    output logic [obj_entry_w-1:0] rdata
);

    localparam int depth = 2 ** table_aw;

    // one entry per object
    logic [obj_entry_w-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];  // registered read, old data on a write cycle
    end

endmodule

`default_nettype wire

// File: hw/obj_table_arb.sv
// object table arbiter
`default_nettype none
`timescale 1ns/10ps

module obj_table_arb import obj_pkg::*; #(
    parameter int table_aw = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    // cpu write port
    input  logic                   cpu_we,
    input  logic [table_aw-1:0]    cpu_addr,
    input  logic [obj_entry_w-1:0] cpu_wdata,
    output logic                   cpu_wait,
    // scanner read port
    input  logic                   scan_busy,
    input  logic [table_aw-1:0]    scan_addr,
    // ram side
    output logic                   ram_we,
    output logic [table_aw-1:0]    ram_addr,
    output logic [obj_entry_w-1:0] ram_wdata
);

    // scanner owns the ram for the whole walk
    assign cpu_wait  = scan_busy;                 // cpu holds its write meanwhile
    assign ram_we    = cpu_we && !scan_busy;
    assign ram_addr  = scan_busy ? scan_addr : cpu_addr;
    assign ram_wdata = cpu_wdata;

    a_no_cpu_write_in_scan: assert property (@(posedge clk) disable iff (rst)
        scan_busy |-> !ram_we)
        else $error("table written during scan");

    // a held back write must stay put until it lands
    a_cpu_holds: assert property (@(posedge clk) disable iff (rst)
        cpu_we && cpu_wait |=> cpu_we && $stable(cpu_addr) && $stable(cpu_wdata))
        else $error("cpu write dropped while waiting");

endmodule

`default_nettype wire

// File: hw/obj_tile_match.sv
// object vertical hit test
`default_nettype none
`timescale 1ns/10ps

module obj_tile_match import obj_pkg::*; (
    input  logic               clk,
    input  logic [field_w-1:0] entry_y,
    input  logic [field_w-1:0] entry_code,
    input  logic [field_w-1:0] entry_attr,
    input  logic [lbuf_aw-1:0] line,
    input  logic [hpos_w-1:0]  off_y,
    output logic               inzone,
    output logic [sub_w-1:0]   vsub,
    output logic [field_w-1:0] code_mn
);

    logic [3:0]         tile_m;  // tiles down minus one
    logic [lbuf_aw-1:0] top;     // top edge on screen
    logic [lbuf_aw-1:0] row;     // line inside the object
    logic [3:0]         trow;    // tile row after vflip

    assign tile_m = entry_attr[15:12];

    // absolute objects ignore the scroll offset
    assign top = entry_attr[7] ? entry_y[lbuf_aw-1:0]
                               : entry_y[lbuf_aw-1:0] - off_y[lbuf_aw-1:0];
    assign row = line - top;  // wraps at 512

    // vflip walks the tile rows bottom up
    assign trow = entry_attr[6] ? tile_m - row[7:4] : row[7:4];

    always_ff @(posedge clk) begin
        inzone  <= row[lbuf_aw-1:sub_w] <= {1'b0, tile_m};  // row < 16*(m+1)
        vsub    <= row[sub_w-1:0];
        code_mn <= entry_code + {8'h00, trow, 4'h0};      // one code row is 16 codes
    end

endmodule

`default_nettype wire

// File: hw/obj_line_scan.sv
// object table scanner
`default_nettype none
`timescale 1ns/10ps

module obj_line_scan import obj_pkg::*; #(
    parameter int table_aw = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic [lbuf_aw-1:0]     line,       // line about to be shown
    input  logic [hpos_w-1:0]      off_x,
    input  logic [hpos_w-1:0]      off_y,
    // table side
    output logic                   scan_busy,
    output logic [table_aw-1:0]    scan_addr,
    input  logic [obj_entry_w-1:0] table_data,
    // drawer side
    input  logic                   dr_idle,
    output logic                   dr_start,
    output logic [field_w-1:0]     dr_code,
    output logic [lbuf_aw-1:0]     dr_hpos,
    output logic [sub_w-1:0]       dr_vsub,
    output logic [pal_w-1:0]       dr_pal,
    output logic                   dr_hflip,
    output logic                   line_done
);

    typedef enum logic [2:0] {
        st_idle, st_addr, st_data, st_match, st_issue, st_step, st_next, st_done
    } scan_st_t;

    scan_st_t           st;
    logic               start_d;
    logic               new_line;
    logic [lbuf_aw-1:0] line_r;
    logic [hpos_w-1:0]  offx_r, offy_r;

    logic [field_w-1:0] ent_x, ent_y, ent_code, ent_attr;
    logic               list_end;
    logic               inzone;
    logic [sub_w-1:0]   vsub;
    logic [field_w-1:0] code_mn;

    logic [hpos_w-1:0]  x_base;     // left edge of tile position 0
    logic [hpos_w-1:0]  hpos_full;
    logic [3:0]         tile_n;     // tiles across minus one
    logic [3:0]         pos;        // tile position on screen
    logic [3:0]         tile_idx;   // tile column in the code map
    logic               hflip_r;
    logic [pal_w-1:0]   pal_r;

    assign {ent_attr, ent_code, ent_y, ent_x} = table_data;
    assign list_end  = ent_y[15] || ent_attr[15:8] == 8'hff;
    assign new_line  = start && !start_d;
    assign hpos_full = x_base + {2'b00, pos, 4'h0};
    assign tile_idx  = hflip_r ? tile_n - pos : pos;  // hflip reverses the columns

    obj_tile_match u_match (
        .clk        ( clk        ),
        .entry_y    ( ent_y      ),
        .entry_code ( ent_code   ),
        .entry_attr ( ent_attr   ),
        .line       ( line_r     ),
        .off_y      ( offy_r     ),
        .inzone     ( inzone     ),
        .vsub       ( vsub       ),
        .code_mn    ( code_mn    )
    );

    // walk fsm, address is held for the whole entry so table_data stays put
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st        <= st_idle;
            start_d   <= 1'b0;
            scan_busy <= 1'b0;
            scan_addr <= '0;
            dr_start  <= 1'b0;
            line_done <= 1'b0;
        end else begin
            start_d   <= start;
            dr_start  <= 1'b0;  // single cycle pulse
            line_done <= 1'b0;
            case (st)
                st_addr:  st <= st_data;  // ram reads the entry
                st_data: begin
                    if (list_end) begin
                        st        <= st_done;
                        scan_busy <= 1'b0;
                    end else begin
                        st <= st_match;
                    end
                end
                st_match: st <= inzone ? st_issue : st_next;
                st_issue: begin
                    if (dr_idle) begin
                        dr_start <= !hpos_full[hpos_w-1];  // off line, drop the tile
                        st       <= st_step;
                    end
                end
                // dr_idle is stale here, drawer has not seen the pulse yet
                st_step:  st <= (pos == tile_n) ? st_next : st_issue;
                st_next: begin
                    if (&scan_addr) begin
                        st        <= st_done;
                        scan_busy <= 1'b0;
                    end else begin
                        scan_addr <= scan_addr + 1'b1;
                        st        <= st_addr;
                    end
                end
                st_done: begin
                    if (dr_idle) begin  // last tile written out
                        line_done <= 1'b1;
                        st        <= st_idle;
                    end
                end
                default:  st <= st_idle;
            endcase
            if (new_line) begin  // a start edge always restarts from entry 0
                st        <= st_addr;
                scan_addr <= '0;
                scan_busy <= 1'b1;
            end
        end
    end

    // entry and command fields
    always_ff @(posedge clk) begin
        if (new_line) begin
            line_r <= line;
            offx_r <= off_x;
            offy_r <= off_y;
        end
        case (st)
            st_data: begin
                x_base  <= ent_attr[7] ? ent_x[hpos_w-1:0] : ent_x[hpos_w-1:0] - offx_r;
                tile_n  <= ent_attr[11:8];
                hflip_r <= ent_attr[5];
                pal_r   <= ent_attr[pal_w-1:0];
            end
            st_match: pos <= '0;
            st_issue: begin
                if (dr_idle) begin
                    dr_code  <= code_mn + {12'h000, tile_idx};
                    dr_hpos  <= hpos_full[lbuf_aw-1:0];
                    dr_vsub  <= vsub;
                    dr_pal   <= pal_r;
                    dr_hflip <= hflip_r;
                end
            end
            st_step: begin
                if (pos != tile_n) begin
                    pos <= pos + 4'd1;
                end
            end
            default: ;
        endcase
    end

    a_start_when_idle: assert property (@(posedge clk) disable iff (rst)
        dr_start |-> dr_idle)
        else $error("draw command issued to a busy drawer");

endmodule

`default_nettype wire

// File: hw/obj_tile_draw.sv
// tile row drawer
`default_nettype none
`timescale 1ns/10ps

module obj_tile_draw import obj_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    // command from the scanner
    input  logic               dr_start,
    input  logic [field_w-1:0] dr_code,
    input  logic [lbuf_aw-1:0] dr_hpos,
    input  logic [sub_w-1:0]   dr_vsub,
    input  logic [pal_w-1:0]   dr_pal,
    input  logic               dr_hflip,
    output logic               dr_idle,
    // graphics rom, data one cycle after address
    output logic [gfx_aw-1:0]  gfx_addr,
    input  logic [gfx_w-1:0]   gfx_data,
    // line buffer write
    output logic               lb_we,
    output logic [lbuf_aw-1:0] lb_addr,
    output logic [lbuf_dw-1:0] lb_data
);

    typedef enum logic [1:0] {dw_idle, dw_req, dw_fetch, dw_write} draw_st_t;

    draw_st_t           st;
    logic [lbuf_aw-1:0] hpos_r;
    logic [pal_w-1:0]   pal_r;
    logic               hflip_r;
    logic [gfx_w-1:0]   row;   // tile row being drawn
    logic [sub_w-1:0]   px;    // screen pixel within the tile
    logic [sub_w-1:0]   sel;   // rom pixel for it
    logic [pix_w-1:0]   pix;

    assign dr_idle = st == dw_idle;
    assign sel     = hflip_r ? ~px : px;  // 15 - k when flipped
    assign pix     = row[sel*pix_w +: pix_w];
    assign lb_we   = st == dw_write && pix != pix_clear;  // skip see-through
    assign lb_addr = hpos_r + lbuf_aw'(px);               // wraps at 512
    assign lb_data = {1'b1, pal_r, pix};

    // req and fetch are the two rom cycles, then 16 writes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st <= dw_idle;
        end else begin
            case (st)
                dw_idle:  if (dr_start) st <= dw_req;
                dw_req:   st <= dw_fetch;
                dw_fetch: st <= dw_write;
                dw_write: if (&px) st <= dw_idle;
                default:  st <= dw_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dr_idle && dr_start) begin
            gfx_addr <= {dr_code, dr_vsub};
            hpos_r   <= dr_hpos;
            pal_r    <= dr_pal;
            hflip_r  <= dr_hflip;
        end
        if (st == dw_fetch) begin
            row <= gfx_data;  // rom output valid this cycle
            px  <= '0;
        end else if (st == dw_write) begin
            px <= px + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/obj_line_buf.sv
// sprite line buffer
`default_nettype none
`timescale 1ns/10ps

module obj_line_buf import obj_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               lb_we,
    input  logic [lbuf_aw-1:0] lb_addr,
    input  logic [lbuf_dw-1:0] lb_data,
    input  logic [lbuf_aw-1:0] rd_addr,
    output logic [lbuf_dw-1:0] rd_data
);

    localparam int depth = 2 ** lbuf_aw;

    logic [lbuf_dw-1:0] mem [depth];
    logic [lbuf_aw-1:0] rd_q;     // address of the previous cycle
    logic               rd_move;  // read strobe

    // an entry counts as read on the cycle rd_addr moves onto it,
    // a held address reads once and is then left alone
    assign rd_move = rd_addr != rd_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_q <= '0;
        end else begin
            rd_q <= rd_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (lb_we && !mem[lb_addr][lbuf_dw-1]) begin
            mem[lb_addr] <= lb_data;  // first writer keeps the spot
        end
        if (rd_move) begin
            mem[rd_addr] <= '0;  // clear behind the readout
        end
        rd_data <= mem[rd_addr];
    end

    a_no_rd_wr_clash: assert property (@(posedge clk) disable iff (rst)
        !(rd_move && lb_we && rd_addr == lb_addr))
        else $error("line buffer read and write hit the same position");

endmodule

`default_nettype wire

// File: hw/obj_engine_top.sv
// sprite line engine top
`default_nettype none
`timescale 1ns/10ps

module obj_engine_top import obj_pkg::*; #(
    parameter int table_aw = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic [lbuf_aw-1:0]     line,
    input  logic [hpos_w-1:0]      off_x,
    input  logic [hpos_w-1:0]      off_y,
    // cpu table writes
    input  logic                   cpu_we,
    input  logic [table_aw-1:0]    cpu_addr,
    input  logic [obj_entry_w-1:0] cpu_wdata,
    output logic                   cpu_wait,
    // graphics rom
    output logic [gfx_aw-1:0]      gfx_addr,
    input  logic [gfx_w-1:0]       gfx_data,
    // pixel readout
    input  logic [lbuf_aw-1:0]     rd_addr,
    output logic [lbuf_dw-1:0]     rd_data,
    output logic                   line_done
);

    logic                   scan_busy;
    logic [table_aw-1:0]    scan_addr;
    logic [obj_entry_w-1:0] table_data;   // ram read data to the scanner
    logic                   ram_we;
    logic [table_aw-1:0]    ram_addr;
    logic [obj_entry_w-1:0] ram_wdata;

    logic                   dr_start, dr_idle, dr_hflip;
    logic [field_w-1:0]     dr_code;
    logic [lbuf_aw-1:0]     dr_hpos;
    logic [sub_w-1:0]       dr_vsub;
    logic [pal_w-1:0]       dr_pal;

    logic                   lb_we;
    logic [lbuf_aw-1:0]     lb_addr;
    logic [lbuf_dw-1:0]     lb_data;

    obj_table_arb #(.table_aw(table_aw)) u_arb (
        .clk, .rst, .cpu_we, .cpu_addr, .cpu_wdata, .cpu_wait,
        .scan_busy, .scan_addr, .ram_we, .ram_addr, .ram_wdata
    );

    obj_table_ram #(.table_aw(table_aw)) u_ram (
        .clk, .we(ram_we), .addr(ram_addr), .wdata(ram_wdata), .rdata(table_data)
    );

    obj_line_scan #(.table_aw(table_aw)) u_scan (
        .clk, .rst, .start, .line, .off_x, .off_y,
        .scan_busy, .scan_addr, .table_data,
        .dr_idle, .dr_start, .dr_code, .dr_hpos, .dr_vsub, .dr_pal, .dr_hflip,
        .line_done
    );

    obj_tile_draw u_draw (
        .clk, .rst, .dr_start, .dr_code, .dr_hpos, .dr_vsub, .dr_pal, .dr_hflip,
        .dr_idle, .gfx_addr, .gfx_data, .lb_we, .lb_addr, .lb_data
    );

    obj_line_buf u_lbuf (
        .clk, .rst, .lb_we, .lb_addr, .lb_data, .rd_addr, .rd_data
    );

endmodule

`default_nettype wire

// File: sim/tb_obj_engine.sv
// sprite engine testbench
`default_nettype none
`timescale 1ns/10ps

module tb_obj_engine import obj_pkg::*; ();

    localparam int table_aw  = 8;
    localparam int n_entries = 2 ** table_aw;
    localparam int n_pos     = 2 ** lbuf_aw;
    localparam int n_lines   = 17;  // lines rendered over all tests
    localparam int n_reads   = 19;  // full readouts, flush included
    // every entry, 16 tiles, 20 cycles a tile, plus readouts and table loads
    localparam int max_cycles = n_lines * n_entries * 16 * 20 + n_reads * 520 + 2000;
    localparam logic [obj_entry_w-1:0] end_mark = 64'h0000_0000_8000_0000;  // y bit 15

    logic                   clk;
    logic                   rst;
    logic                   start;
    logic [lbuf_aw-1:0]     line;
    logic [hpos_w-1:0]      off_x;
    logic [hpos_w-1:0]      off_y;
    logic                   cpu_we;
    logic [table_aw-1:0]    cpu_addr;
    logic [obj_entry_w-1:0] cpu_wdata;
    logic                   cpu_wait;
    logic [gfx_aw-1:0]      gfx_addr;
    logic [gfx_w-1:0]       gfx_data = '0;      // rom output before the first fetch
    logic [lbuf_aw-1:0]     rd_addr;
    logic [lbuf_dw-1:0]     rd_data;
    logic                   line_done;

    logic [obj_entry_w-1:0] tbl [n_entries];    // model copy of the table
    logic [lbuf_dw-1:0]     exp_line [n_pos];   // expected line
    int                     cycles = 0;
    int                     done_cnt = 0;
    int                     done_target;

    obj_engine_top #(.table_aw(table_aw)) dut (
        .clk, .rst, .start, .line, .off_x, .off_y,
        .cpu_we, .cpu_addr, .cpu_wdata, .cpu_wait,
        .gfx_addr, .gfx_data, .rd_addr, .rd_data, .line_done
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns
    end

    // rom contents, hashed from the full {code, vsub} address
    function automatic logic [gfx_w-1:0] gfx_row(input logic [gfx_aw-1:0] a);
        logic [gfx_w-1:0] r;
        logic [31:0]      t;
        int               k;
        for (k = 0; k < tile_px; k++) begin
            t = 32'(a) * 32'h2c1b3c6d + k * 32'h6a09e667;
            t = t ^ (t >> 16);  // pull high address bits down
            t = t * 32'h85ebca6b;
            t = t ^ (t >> 13);
            r[k*pix_w +: pix_w] = (t[9:7] == 3'd0) ? 4'hf : t[3:0];  // extra holes
        end
        return r;
    endfunction

    always @(posedge clk) begin
        gfx_data <= gfx_row(gfx_addr);  // registered rom output
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            stop_run($sformatf("** Error at %0t: %s, got %h, expected %h",
                               $time, what, got, want));
        end
    endtask

    // cycle limit and line_done counting
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (line_done) begin
            done_cnt <= done_cnt + 1;
        end
        if (cycles >= max_cycles) begin
            stop_run($sformatf("Timeout: line never finished within %0d cycles", max_cycles));
        end
    end

    // reference renderer, walks tbl in order, first opaque pixel wins
    function automatic void render_line(input logic [lbuf_aw-1:0] ln,
                                        input logic [hpos_w-1:0] ox,
                                        input logic [hpos_w-1:0] oy);
        logic [15:0]        x, y, code, attr, code_mn, tc;
        logic [3:0]         m, n, tr, ti, sel;
        logic [8:0]         top, row, a;
        logic [9:0]         xb, hp;
        logic [gfx_w-1:0]   grow;
        logic [pix_w-1:0]   pix;
        int                 e, p, k;
        for (k = 0; k < n_pos; k++) begin
            exp_line[k] = '0;
        end
        for (e = 0; e < n_entries; e++) begin
            {attr, code, y, x} = tbl[e];
            if (y[15] || attr[15:8] == 8'hff) break;  // end of list
            m   = attr[15:12];
            n   = attr[11:8];
            top = attr[7] ? y[8:0] : y[8:0] - oy[8:0];
            row = ln - top;
            if (int'(row) >= 16 * (int'(m) + 1)) continue;  // not on this line
            tr      = attr[6] ? m - row[7:4] : row[7:4];     // vflip
            code_mn = code + 16'(tr) * 16'd16;
            xb      = attr[7] ? x[9:0] : x[9:0] - ox;
            for (p = 0; p <= int'(n); p++) begin
                hp = xb + 10'(p * 16);
                if (hp[9]) continue;  // tile dropped
                ti   = attr[5] ? n - 4'(p) : 4'(p);
                tc   = code_mn + 16'(ti);
                grow = gfx_row({tc, row[3:0]});
                for (k = 0; k < tile_px; k++) begin
                    sel = attr[5] ? 4'(15 - k) : 4'(k);  // hflip mirrors pixels
                    pix = grow[sel*pix_w +: pix_w];
                    a   = hp[8:0] + 9'(k);
                    if (pix != 4'hf && !exp_line[a][lbuf_dw-1]) begin
                        exp_line[a] = {1'b1, attr[4:0], pix};
                    end
                end
            end
        end
    endfunction

    // up to 4x4 tiles, never an end marker
    function automatic logic [15:0] rand_attr(input bit absolute);
        logic [15:0] r;
        r        = 16'($urandom);
        r[15:14] = 2'b00;
        r[11:10] = 2'b00;
        r[7]     = absolute;
        return r;
    endfunction

    // object whose top edge lands so that it covers line ln
    function automatic logic [obj_entry_w-1:0] rand_obj(input logic [lbuf_aw-1:0] ln,
                                                        input logic [15:0] x,
                                                        input bit absolute,
                                                        input logic [8:0] oy);
        logic [15:0] attr, y;
        int          span, r;
        attr = rand_attr(absolute);
        span = 16 * (int'(attr[15:12]) + 1);
        r    = int'($urandom % 32'(span));
        y    = 16'(9'(int'(ln) + int'(oy) - r));  // wraps at 512
        return {attr, 16'($urandom), y, x};
    endfunction

    task automatic write_entry(input int idx, input logic [obj_entry_w-1:0] data);
        tbl[idx]  = data;
        cpu_we    = 1'b1;
        cpu_addr  = table_aw'(idx);
        cpu_wdata = data;
        while (cpu_wait) begin
            @(negedge clk);  // held while the scanner owns the table
        end
        @(negedge clk);  // lands on the edge just passed
        cpu_we = 1'b0;
    endtask

    task automatic start_line(input logic [lbuf_aw-1:0] ln, input logic [hpos_w-1:0] ox,
                              input logic [hpos_w-1:0] oy);
        line        = ln;
        off_x       = ox;
        off_y       = oy;
        done_target = done_cnt + 1;
        start       = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_done();
        while (done_cnt < done_target) begin
            @(negedge clk);
        end
    endtask

    // rd_addr sweeps 0..511 and stays parked at 511
    task automatic readout(input bit compare);
        int i;
        for (i = 0; i < n_pos; i++) begin
            rd_addr = lbuf_aw'(i);
            @(negedge clk);
            if (compare) begin
                check($sformatf("pixel %0d", i), 32'(rd_data), 32'(exp_line[i]));
            end
        end
    endtask

    task automatic run_line(input logic [lbuf_aw-1:0] ln, input logic [hpos_w-1:0] ox,
                            input logic [hpos_w-1:0] oy);
        render_line(ln, ox, oy);
        start_line(ln, ox, oy);
        wait_done();
        readout(1'b1);
    endtask

    initial begin
        logic [lbuf_aw-1:0]     ln;
        logic [hpos_w-1:0]      ox, oy;
        logic [obj_entry_w-1:0] obj;
        int                     i;
        void'($urandom(32'h0b6790c4));
        rst       = 1'b1;
        start     = 1'b0;
        line      = '0;
        off_x     = '0;
        off_y     = '0;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        rd_addr   = '1;  // parked, so the first sweep clears address 0 too
        repeat (4) @(negedge clk);
        rst = 1'b0;
        readout(1'b0);  // flush power up contents

        // empty table
        write_entry(0, end_mark);
        run_line(9'd100, '0, '0);

        // single objects, sizes and flips at random
        repeat (8) begin
            ln = lbuf_aw'($urandom);
            write_entry(0, rand_obj(ln, 16'($urandom % 480), 1'($urandom), 9'd0));
            write_entry(1, end_mark);
            run_line(ln, '0, '0);
        end

        // pile of objects on one spot
        repeat (3) begin
            ln = lbuf_aw'($urandom);
            for (i = 0; i < 6; i++) begin
                write_entry(i, rand_obj(ln, 16'(100 + $urandom % 40), 1'b0, 9'd0));
            end
            // random height, mostly misses the line
            write_entry(6, {rand_attr(1'b0), 16'($urandom), 16'($urandom % 512),
                            16'($urandom % 480)});
            write_entry(7, end_mark);
            run_line(ln, '0, '0);
        end

        // scroll offsets against absolute objects
        repeat (3) begin
            ln = lbuf_aw'($urandom);
            ox = hpos_w'(64 + $urandom % 128);
            oy = hpos_w'($urandom % 512);
            write_entry(0, rand_obj(ln, 16'(ox) + 16'($urandom % 400), 1'b0, oy[8:0]));
            write_entry(1, rand_obj(ln, 16'($urandom % 400), 1'b1, 9'd0));
            obj = rand_obj(ln, 16'(ox) - 16'd32, 1'b0, oy[8:0]);
            obj[59:56] = 4'd3;  // 4 across, left two wrap to 992 and 1008
            write_entry(2, obj);
            write_entry(3, end_mark);
            run_line(ln, ox, oy);
        end

        // table rewritten while a line runs
        ln = lbuf_aw'($urandom);
        for (i = 0; i < 3; i++) begin
            write_entry(i, rand_obj(ln, 16'($urandom % 480), 1'b0, 9'd0));
        end
        write_entry(3, end_mark);
        render_line(ln, '0, '0);  // this line still sees the old table
        start_line(ln, '0, '0);
        check("cpu_wait during scan", 32'(cpu_wait), 32'd1);
        for (i = 0; i < 4; i++) begin
            write_entry(i, rand_obj(ln, 16'($urandom % 480), 1'b0, 9'd0));
        end
        write_entry(4, end_mark);
        wait_done();
        readout(1'b1);
        run_line(ln, '0, '0);  // new entries now in place

        // second sweep finds the line cleared
        for (i = 0; i < n_pos; i++) begin
            exp_line[i] = '0;
        end
        readout(1'b1);

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
hw/obj_pkg.sv
hw/obj_table_ram.sv
hw/obj_table_arb.sv
hw/obj_tile_match.sv
hw/obj_line_scan.sv
hw/obj_tile_draw.sv
hw/obj_line_buf.sv
hw/obj_engine_top.sv
sim/tb_obj_engine.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the sprite engine testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_obj_engine -f list.f -o sim_obj_engine; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/sim_obj_engine; then
    echo "simulation run failed"
    exit 1
fi

exit 0
